//--- src/noc_router_pkg.sv
//////////////////////////////
// Shared types and constants of the mesh router
// Imported by every router block and by the testbench
//////////////////////////////

package noc_router_pkg;

  //////////////////////////////
  // Mesh coordinates
  //////////////////////////////

  localparam int coord_width = 3;

  typedef logic [coord_width-1:0] coord_t;

  // One router on the mesh
  typedef struct packed {
    coord_t x;
    coord_t y;
  } xy_t;

  //////////////////////////////
  // Ports and routing field
  //////////////////////////////

  // Port index, also the bit position in a direction
  typedef enum logic [2:0] {
    north_port = 3'd0,
    south_port = 3'd1,
    west_port  = 3'd2,
    east_port  = 3'd3,
    local_port = 3'd4
  } port_e;

  // One-hot output select
  typedef logic [4:0] direction_t;

  localparam direction_t go_north = 5'b00001;
  localparam direction_t go_south = 5'b00010;
  localparam direction_t go_west  = 5'b00100;
  localparam direction_t go_east  = 5'b01000;
  localparam direction_t go_local = 5'b10000;

  //////////////////////////////
  // Flit format
  //////////////////////////////

  localparam int data_width = 32;

  // Message type carried by the head flit
  typedef enum logic [1:0] {
    msg_request   = 2'd0,
    msg_response  = 2'd1,
    msg_interrupt = 2'd2,
    msg_config    = 2'd3
  } msg_e;

  // Head and tail both set marks a single-flit packet
  typedef struct packed {
    logic head;
    logic tail;
  } preamble_t;

  // Bits left over in the head flit after the used fields
  localparam int reserved_width =
    data_width - 2 * $bits(xy_t) - $bits(msg_e) - $bits(direction_t);

  // Routing field sits in the low bits
  typedef struct packed {
    xy_t                       source;
    xy_t                       destination;
    msg_e                      msg;
    logic [reserved_width-1:0] reserved;
    direction_t                routing;
  } header_t;

  typedef union packed {
    header_t               header;
    logic [data_width-1:0] payload;
  } flit_data_u;

  typedef struct packed {
    preamble_t  preamble;
    flit_data_u data;
  } flit_t;

  //////////////////////////////
  // Queues and output control
  //////////////////////////////

  localparam int queue_depth     = 4;
  localparam int queue_ptr_width = $clog2(queue_depth);

  typedef enum logic {
    head_flit     = 1'b0,
    payload_flits = 1'b1
  } wormhole_state_e;

endpackage

//--- src/router_input_fifo.sv
//////////////////////////////
// Input flit queue, shows the incoming flit while empty
//////////////////////////////

`timescale 1ns/10ps

module router_input_fifo (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr_i,
  input  noc_router_pkg::flit_t data_i,
  input  logic                  rd_i,
  output noc_router_pkg::flit_t data_o,
  output logic                  empty_o,
  output logic                  full_o
);

  import noc_router_pkg::*;

  // Storage, no reset on the payload
  flit_t mem [queue_depth];

  logic [queue_ptr_width-1:0] rd_ptr;
  logic [queue_ptr_width-1:0] wr_ptr;
  logic [queue_ptr_width:0]   count;
  logic                       do_wr;
  logic                       do_rd;

  assign empty_o = (count == '0);
  assign full_o  = (count == (queue_ptr_width + 1)'(queue_depth));

  // Drop a write on full and a read on empty
  assign do_wr = wr_i & ~full_o;
  assign do_rd = rd_i & ~empty_o;

  // Bypass: empty queue exposes the flit on the link
  assign data_o = empty_o ? data_i : mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Occupancy only moves when one side acts alone
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/router_input_unit.sv
//////////////////////////////
// One router input: queue, stop level and worm request
//////////////////////////////

`timescale 1ns/10ps

module router_input_unit (
  input  logic                       clk,
  input  logic                       rst,
  input  noc_router_pkg::flit_t      flit_i,
  input  logic                       void_i,
  input  logic [4:0]                 rd_i,
  output logic                       stop_o,
  output noc_router_pkg::flit_t      head_o,
  output logic                       head_valid_o,
  output noc_router_pkg::direction_t request_o
);

  import noc_router_pkg::*;

  logic       pop;
  logic       empty;
  logic       full;
  logic       front_head;
  direction_t saved_request;

  // At most one output reads this input at a time
  assign pop = |rd_i;

  router_input_fifo i_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr_i    (~void_i),
    .data_i  (flit_i),
    .rd_i    (pop),
    .data_o  (head_o),
    .empty_o (empty),
    .full_o  (full)
  );

  // NACK toward the sender once the queue is full
  assign stop_o = full;

  // Only stored flits are offered to the outputs
  assign head_valid_o = ~empty;
  assign front_head   = head_valid_o & head_o.preamble.head;

  //////////////////////////////
  // Worm request
  //////////////////////////////

  // Routing field of the current worm, kept until its tail leaves
  always_ff @(posedge clk) begin
    if (rst) begin
      saved_request <= '0;
    end else if (pop && head_o.preamble.tail) begin
      saved_request <= '0;
    end else if (front_head) begin
      saved_request <= head_o.data.header.routing;
    end
  end

  // Head at the front asks directly, body flits reuse the saved route
  assign request_o = front_head ? head_o.data.header.routing : saved_request;

endmodule

//--- src/router_arbiter.sv
//////////////////////////////
// Round-robin arbiter over four inputs, locked for a whole worm
//////////////////////////////

`timescale 1ns/10ps

module router_arbiter (
  input  logic       clk,
  input  logic       rst,
  input  logic [3:0] request_i,
  input  logic       forwarding_head_i,
  input  logic       forwarding_tail_i,
  output logic [3:0] grant_o,
  output logic       grant_valid_o
);

  logic [1:0] prio_ptr;
  logic       locked;
  logic [1:0] held_idx;
  logic [3:0] pick;
  logic [1:0] pick_idx;
  logic [1:0] winner_idx;

  // First requester at or after the priority pointer
  always_comb begin
    logic [1:0] idx;
    logic       found;
    pick     = '0;
    pick_idx = prio_ptr;
    found    = 1'b0;
    for (int i = 0; i < 4; i++) begin
      idx = prio_ptr + 2'(i);
      if (!found && request_i[idx]) begin
        pick[idx] = 1'b1;
        pick_idx  = idx;
        found     = 1'b1;
      end
    end
  end

  // Locked grant ignores new requests until the tail
  assign grant_o       = locked ? (4'b0001 << held_idx) : pick;
  assign grant_valid_o = |grant_o;
  assign winner_idx    = locked ? held_idx : pick_idx;

  always_ff @(posedge clk) begin
    if (rst) begin
      prio_ptr <= '0;
      locked   <= 1'b0;
      held_idx <= '0;
    end else if (forwarding_tail_i) begin
      // Also covers single-flit packets, head and tail together
      locked   <= 1'b0;
      prio_ptr <= winner_idx + 2'd1;
    end else if (forwarding_head_i) begin
      locked   <= 1'b1;
      held_idx <= pick_idx;
    end
  end

endmodule

//--- src/lookahead_xy_route.sv
//////////////////////////////
// XY route for the next hop, written into the head flit
//////////////////////////////

`timescale 1ns/10ps

module lookahead_xy_route (
  input  noc_router_pkg::xy_t        position_i,
  input  noc_router_pkg::port_e      out_port_i,
  input  noc_router_pkg::xy_t        destination_i,
  output noc_router_pkg::direction_t next_route_o
);

  import noc_router_pkg::*;

  xy_t next_pos;

  // Coordinate of the router behind the chosen output
  // Y grows toward South, X grows toward East
  always_comb begin
    next_pos = position_i;
    case (out_port_i)
      north_port: next_pos.y = position_i.y - coord_t'(1);
      south_port: next_pos.y = position_i.y + coord_t'(1);
      west_port:  next_pos.x = position_i.x - coord_t'(1);
      east_port:  next_pos.x = position_i.x + coord_t'(1);
      default:    next_pos   = position_i;
    endcase
  end

  // Dimension order, X first then Y
  always_comb begin
    if (out_port_i == local_port) begin
      // Packet leaves the mesh here
      next_route_o = go_local;
    end else if (destination_i.x > next_pos.x) begin
      next_route_o = go_east;
    end else if (destination_i.x < next_pos.x) begin
      next_route_o = go_west;
    end else if (destination_i.y > next_pos.y) begin
      next_route_o = go_south;
    end else if (destination_i.y < next_pos.y) begin
      next_route_o = go_north;
    end else begin
      next_route_o = go_local;
    end
  end

endmodule

//--- src/router_output_unit.sv
//////////////////////////////
// One router output: wormhole FSM, crossbar mux and output register
// Look-ahead route replaces the routing field of each head
//////////////////////////////

`timescale 1ns/10ps

module router_output_unit #(
  parameter noc_router_pkg::port_e out_port = noc_router_pkg::local_port
) (
  input  logic                             clk,
  input  logic                             rst,
  input  noc_router_pkg::xy_t              position_i,
  input  noc_router_pkg::flit_t [4:0]      heads_i,
  input  logic [4:0]                       head_valid_i,
  input  noc_router_pkg::direction_t [4:0] requests_i,
  input  logic                             stop_i,
  output logic [4:0]                       rd_o,
  output noc_router_pkg::flit_t            data_o,
  output logic                             void_o
);

  import noc_router_pkg::*;

  wormhole_state_e state;
  wormhole_state_e state_next;

  logic [3:0] request;
  logic [3:0] grant;
  logic       grant_valid;
  logic [4:0] grant_sel;
  logic [4:0] saved_sel;
  logic [4:0] sel;
  flit_t      sel_flit;
  flit_t      out_flit;
  logic       sel_valid;
  logic       advance;
  logic       forwarding_head;
  logic       forwarding_tail;
  direction_t next_route;

  //////////////////////////////
  // Arbitration
  //////////////////////////////

  // Four candidate inputs, own port skipped
  // Only a stored flit may raise a request
  always_comb begin
    int in_idx;
    request = '0;
    for (int k = 0; k < 4; k++) begin
      in_idx     = (k < int'(out_port)) ? k : k + 1;
      request[k] = requests_i[in_idx][out_port] & head_valid_i[in_idx];
    end
  end

  router_arbiter i_arbiter (
    .clk               (clk),
    .rst               (rst),
    .request_i         (request),
    .forwarding_head_i (forwarding_head),
    .forwarding_tail_i (forwarding_tail),
    .grant_o           (grant),
    .grant_valid_o     (grant_valid)
  );

  // Back to the five-input index space
  always_comb begin
    int in_idx;
    grant_sel = '0;
    for (int k = 0; k < 4; k++) begin
      in_idx            = (k < int'(out_port)) ? k : k + 1;
      grant_sel[in_idx] = grant[k];
    end
  end

  //////////////////////////////
  // Crossbar and flow control
  //////////////////////////////

  // Body flits follow the input saved at the head
  assign sel = (state == payload_flits) ? saved_sel : grant_sel;

  always_comb begin
    sel_flit = '0;
    for (int i = 0; i < 5; i++) begin
      if (sel[i]) begin
        sel_flit = heads_i[i];
      end
    end
  end

  assign sel_valid = (state == payload_flits) ? |(saved_sel & head_valid_i) : grant_valid;

  // Downstream stop freezes the output and the granted queue
  assign advance         = sel_valid & ~stop_i;
  assign forwarding_head = advance & (state == head_flit);
  assign forwarding_tail = advance & sel_flit.preamble.tail;
  assign rd_o            = advance ? sel : 5'b00000;

  //////////////////////////////
  // Look-ahead insertion
  //////////////////////////////

  lookahead_xy_route i_route (
    .position_i    (position_i),
    .out_port_i    (out_port),
    .destination_i (sel_flit.data.header.destination),
    .next_route_o  (next_route)
  );

  // Payload flits pass untouched
  always_comb begin
    out_flit = sel_flit;
    if (state == head_flit) begin
      out_flit.data.header.routing = next_route;
    end
  end

  //////////////////////////////
  // Wormhole FSM and output register
  //////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      head_flit: begin
        // Single-flit packet stays in head_flit
        if (forwarding_head && !sel_flit.preamble.tail) begin
          state_next = payload_flits;
        end
      end
      payload_flits: begin
        if (forwarding_tail) begin
          state_next = head_flit;
        end
      end
      default: state_next = head_flit;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= head_flit;
      saved_sel <= '0;
      void_o    <= 1'b1;
    end else begin
      state <= state_next;
      if (forwarding_head) begin
        saved_sel <= sel;
      end
      // Void level only changes while downstream accepts
      if (!stop_i) begin
        void_o <= ~advance;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      data_o <= out_flit;
    end
  end

endmodule

//--- src/noc_router.sv
//////////////////////////////
// Five-port wormhole router for a 2D mesh, XY look-ahead routing
//////////////////////////////

`timescale 1ns/10ps

module noc_router (
  input  logic                        clk,
  input  logic                        rst,
  input  noc_router_pkg::xy_t         position_i,
  input  noc_router_pkg::flit_t [4:0] data_i,
  input  logic [4:0]                  void_i,
  output logic [4:0]                  stop_o,
  output noc_router_pkg::flit_t [4:0] data_o,
  output logic [4:0]                  void_o,
  input  logic [4:0]                  stop_i
);

  import noc_router_pkg::*;

  // Queue fronts and requests, shared by all outputs
  flit_t [4:0]      heads;
  logic [4:0]       head_valid;
  direction_t [4:0] requests;

  // Read vectors, first index output then input
  logic [4:0][4:0] rd_from_output;
  // Same bits regrouped per input
  logic [4:0][4:0] rd_to_input;

  //////////////////////////////
  // Input side
  //////////////////////////////

  for (genvar p = 0; p < 5; p++) begin : gen_input
    for (genvar o = 0; o < 5; o++) begin : gen_rd
      assign rd_to_input[p][o] = rd_from_output[o][p];
    end

    router_input_unit i_input (
      .clk          (clk),
      .rst          (rst),
      .flit_i       (data_i[p]),
      .void_i       (void_i[p]),
      .rd_i         (rd_to_input[p]),
      .stop_o       (stop_o[p]),
      .head_o       (heads[p]),
      .head_valid_o (head_valid[p]),
      .request_o    (requests[p])
    );
  end

  //////////////////////////////
  // Output side
  //////////////////////////////

  for (genvar p = 0; p < 5; p++) begin : gen_output
    router_output_unit #(
      .out_port (port_e'(p))
    ) i_output (
      .clk          (clk),
      .rst          (rst),
      .position_i   (position_i),
      .heads_i      (heads),
      .head_valid_i (head_valid),
      .requests_i   (requests),
      .stop_i       (stop_i[p]),
      .rd_o         (rd_from_output[p]),
      .data_o       (data_o[p]),
      .void_o       (void_o[p])
    );
  end

endmodule

//--- sim/noc_router_sva.sv
//////////////////////////////
// Router properties checked on the top level through bind
//////////////////////////////

`timescale 1ns/10ps

module noc_router_sva (
  input logic                        clk,
  input logic                        rst,
  input noc_router_pkg::flit_t [4:0] data_o,
  input logic [4:0]                  void_o,
  input logic [4:0]                  stop_i,
  input logic [4:0][4:0]             rd_to_input
);

  import noc_router_pkg::*;

  // Next-hop routes that XY order still allows after leaving through out
  function automatic direction_t xy_next_routes(input port_e out);
    case (out)
      north_port: return go_north | go_local;
      south_port: return go_south | go_local;
      west_port:  return go_west | go_north | go_south | go_local;
      east_port:  return go_east | go_north | go_south | go_local;
      default:    return go_local;
    endcase
  endfunction

  for (genvar p = 0; p < 5; p++) begin : gen_port
    // Stopped output keeps its flit on the link
    assert property (@(posedge clk) disable iff (rst)
      (stop_i[p] && !void_o[p]) |=> ($stable(void_o[p]) && $stable(data_o[p])))
      else $error("output %0d changed while stopped", p);

    // One grant per queue front
    assert property (@(posedge clk) disable iff (rst) $onehot0(rd_to_input[p]))
      else $error("input %0d read by two outputs", p);

    // Look-ahead field of a head names one hop, never a turn back or a late X hop
    assert property (@(posedge clk) disable iff (rst)
      (!void_o[p] && data_o[p].preamble.head)
        |-> ($onehot(data_o[p].data.header.routing)
             && ((data_o[p].data.header.routing & ~xy_next_routes(port_e'(p))) == '0)))
      else $error("head on output %0d has a bad routing field", p);
  end

endmodule

//--- sim/tb_noc_router.sv
//////////////////////////////
// Directed testbench for the five-port mesh router at (2,2)
// Drives worms into the inputs and checks what leaves the outputs
//////////////////////////////

`timescale 1ns/10ps

module tb_noc_router;

  import noc_router_pkg::*;

  localparam int clk_period   = 100;
  localparam int reset_cycles = 4;
  // Flits injected by all tests together
  localparam int total_flits  = 4 + 5 + 8 + 10;
  // Per-flit budget covers arbitration and the stalled stretch
  localparam int watchdog_cycles = reset_cycles + 20 * total_flits + 100;

  logic        clk;
  logic        rst;
  xy_t         position;
  flit_t [4:0] data_in;
  logic [4:0]  void_in;
  logic [4:0]  stop_out;
  flit_t [4:0] data_out;
  logic [4:0]  void_out;
  logic [4:0]  stop_in;

  integer seed;
  int     cycle_count = 0;
  int     head_accept_cycle [5];
  // Flits taken off each output and the cycle each one was seen in
  flit_t  rx_flits [5][$];
  int     rx_cycles [5][$];

  noc_router i_dut (
    .clk        (clk),
    .rst        (rst),
    .position_i (position),
    .data_i     (data_in),
    .void_i     (void_in),
    .stop_o     (stop_out),
    .data_o     (data_out),
    .void_o     (void_out),
    .stop_i     (stop_in)
  );

  bind noc_router noc_router_sva i_sva (
    .clk         (clk),
    .rst         (rst),
    .data_o      (data_o),
    .void_o      (void_o),
    .stop_i      (stop_i),
    .rd_to_input (rd_to_input)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk) cycle_count <= cycle_count + 1;

  // A flit counts as taken when it is shown and the output is not stopped
  always @(negedge clk) begin
    if (!rst) begin
      for (int p = 0; p < 5; p++) begin
        if (!void_out[p] && !stop_in[p]) begin
          rx_flits[p].push_back(data_out[p]);
          rx_cycles[p].push_back(cycle_count);
        end
      end
    end
  end

  //////////////////////////////
  // Reporting and reference model
  //////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_flit(input string test, input flit_t exp, input flit_t act);
    assert (act === exp) else begin
      abort_run($sformatf("ERROR %s: expected %h, actual %h", test, exp, act));
    end
  endtask

  task automatic check_word(input string test, input logic [31:0] exp,
                            input logic [31:0] act);
    assert (act === exp) else begin
      abort_run($sformatf("ERROR %s: expected %0d, actual %0d", test, exp, act));
    end
  endtask

  function automatic xy_t make_xy(input int x, input int y);
    xy_t r;
    r.x = coord_t'(x);
    r.y = coord_t'(y);
    return r;
  endfunction

  // XY rule seen from the router behind output out
  function automatic direction_t next_hop_route(input port_e out, input xy_t dst);
    int nx;
    int ny;
    nx = int'(position.x);
    ny = int'(position.y);
    if (out == north_port) ny = ny - 1;
    if (out == south_port) ny = ny + 1;
    if (out == west_port)  nx = nx - 1;
    if (out == east_port)  nx = nx + 1;
    if (out == local_port) return go_local;
    if (int'(dst.x) > nx) return go_east;
    if (int'(dst.x) < nx) return go_west;
    if (int'(dst.y) > ny) return go_south;
    if (int'(dst.y) < ny) return go_north;
    return go_local;
  endfunction

  function automatic flit_t expect_head(input flit_t in, input port_e out);
    flit_t f;
    f = in;
    f.data.header.routing = next_hop_route(out, in.data.header.destination);
    return f;
  endfunction

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Head first, tail on the last flit, random source and payload
  task automatic build_worm(input xy_t dst, input direction_t route, input int len,
                            output flit_t worm[$]);
    flit_t f;
    worm.delete();
    for (int i = 0; i < len; i++) begin
      f = '0;
      f.preamble.head = (i == 0);
      f.preamble.tail = (i == len - 1);
      if (i == 0) begin
        f.data.header.source.x    = coord_t'($random(seed));
        f.data.header.source.y    = coord_t'($random(seed));
        f.data.header.destination = dst;
        f.data.header.msg         = msg_e'(2'($random(seed)));
        f.data.header.reserved    = reserved_width'($random(seed));
        f.data.header.routing     = route;
      end else begin
        f.data.payload = $random(seed);
      end
      worm.push_back(f);
    end
  endtask

  // Offer each flit until a cycle with stop_o low takes it
  task automatic send_worm(input port_e p, input flit_t flits[$]);
    for (int i = 0; i < flits.size(); i++) begin
      @(posedge clk);
      data_in[p] <= flits[i];
      void_in[p] <= 1'b0;
      @(negedge clk);
      while (stop_out[p]) begin
        @(negedge clk);
      end
      if (i == 0) head_accept_cycle[p] = cycle_count + 1;
    end
    @(posedge clk);
    void_in[p] <= 1'b1;
  endtask

  task automatic wait_rx(input port_e p, input int n);
    while (rx_flits[p].size() < n) begin
      @(posedge clk);
    end
  endtask

  task automatic clear_rx();
    for (int p = 0; p < 5; p++) begin
      rx_flits[p].delete();
      rx_cycles[p].delete();
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic reset_state_test();
    check_word("reset_state void_o", 32'h1f, 32'(void_out));
    check_word("reset_state stop_o", 32'h00, 32'(stop_out));
  endtask

  // One single-flit packet from Local toward each neighbor
  task automatic single_flit_test();
    flit_t      pkt [$];
    flit_t      one [$];
    xy_t        dst [4];
    direction_t route [4];
    port_e      outs [4];
    outs[0] = north_port;
    outs[1] = south_port;
    outs[2] = west_port;
    outs[3] = east_port;
    dst[0] = make_xy(2, 0);
    dst[1] = make_xy(2, 4);
    dst[2] = make_xy(0, 1);
    dst[3] = make_xy(3, 2);
    route[0] = go_north;
    route[1] = go_south;
    route[2] = go_west;
    route[3] = go_east;
    for (int i = 0; i < 4; i++) begin
      build_worm(dst[i], route[i], 1, one);
      pkt.push_back(one[0]);
    end
    send_worm(local_port, pkt);
    for (int i = 0; i < 4; i++) begin
      wait_rx(outs[i], 1);
      check_flit("single_flit", expect_head(pkt[i], outs[i]), rx_flits[outs[i]][0]);
    end
    clear_rx();
  endtask

  task automatic worm_order_test();
    flit_t worm [$];
    build_worm(make_xy(5, 3), go_east, 5, worm);
    send_worm(west_port, worm);
    wait_rx(east_port, 5);
    check_word("worm_order latency", 32'(head_accept_cycle[west_port] + 1),
               32'(rx_cycles[east_port][0]));
    check_flit("worm_order", expect_head(worm[0], east_port), rx_flits[east_port][0]);
    for (int i = 1; i < 5; i++) begin
      check_flit("worm_order", worm[i], rx_flits[east_port][i]);
    end
    repeat (3) @(posedge clk);
    check_word("worm_order count", 32'd5, 32'(rx_flits[east_port].size()));
    clear_rx();
  endtask

  // North and South compete for Local and must not interleave
  task automatic contention_test();
    flit_t north_worm [$];
    flit_t south_worm [$];
    flit_t first_worm [$];
    flit_t second_worm [$];
    build_worm(make_xy(2, 2), go_local, 4, north_worm);
    build_worm(make_xy(2, 2), go_local, 4, south_worm);
    fork
      send_worm(north_port, north_worm);
      send_worm(south_port, south_worm);
    join
    wait_rx(local_port, 8);
    if (rx_flits[local_port][0] === north_worm[0]) begin
      first_worm  = north_worm;
      second_worm = south_worm;
    end else begin
      first_worm  = south_worm;
      second_worm = north_worm;
    end
    check_flit("contention first", expect_head(first_worm[0], local_port),
               rx_flits[local_port][0]);
    check_flit("contention second", expect_head(second_worm[0], local_port),
               rx_flits[local_port][4]);
    for (int i = 1; i < 4; i++) begin
      check_flit("contention first", first_worm[i], rx_flits[local_port][i]);
      check_flit("contention second", second_worm[i], rx_flits[local_port][i + 4]);
    end
    repeat (3) @(posedge clk);
    check_word("contention count", 32'd8, 32'(rx_flits[local_port].size()));
    clear_rx();
  endtask

  // East held stopped until the West queue pushes back
  task automatic backpressure_test();
    flit_t worm [$];
    logic  sent;
    build_worm(make_xy(6, 5), go_east, 10, worm);
    sent = 1'b0;
    @(posedge clk);
    stop_in[east_port] <= 1'b1;
    fork
      begin
        send_worm(west_port, worm);
        sent = 1'b1;
      end
      begin
        @(negedge clk);
        while (!stop_out[west_port]) begin
          @(negedge clk);
        end
        assert (!sent) else begin
          abort_run("stop_o on West did not rise before the worm was sent");
        end
        @(posedge clk);
        stop_in[east_port] <= 1'b0;
      end
    join
    wait_rx(east_port, 10);
    check_flit("backpressure", expect_head(worm[0], east_port), rx_flits[east_port][0]);
    for (int i = 1; i < 10; i++) begin
      check_flit("backpressure", worm[i], rx_flits[east_port][i]);
    end
    repeat (3) @(posedge clk);
    check_word("backpressure count", 32'd10, 32'(rx_flits[east_port].size()));
    clear_rx();
  endtask

  //////////////////////////////
  // Run control
  //////////////////////////////

  initial begin
    #(watchdog_cycles * clk_period);
    abort_run("Watchdog timeout, the router did not finish the tests in time");
  end

  initial begin
    seed     = 32'he1b9;
    position = make_xy(2, 2);
    data_in  = '0;
    void_in  = 5'b11111;
    stop_in  = 5'b00000;
    rst      = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    reset_state_test();
    single_flit_test();
    worm_order_test();
    contention_test();
    backpressure_test();
    $display("Test passed");
    $finish;
  end

endmodule

//--- sources.f
src/noc_router_pkg.sv
src/router_input_fifo.sv
src/router_input_unit.sv
src/router_arbiter.sv
src/lookahead_xy_route.sv
src/router_output_unit.sv
src/noc_router.sv
sim/noc_router_sva.sv
sim/tb_noc_router.sv

//--- Makefile
# Verilator flow for the router testbench
# Any variable can be overridden, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_noc_router
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# The log decides the result, the simulator status alone does not
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
